/* flist.f */
+incdir+include
verilog/stat_pkg.sv
verilog/aoi_window.sv
verilog/grey_statis.sv
verilog/frame_interrupt.sv
verilog/stat_regs.sv
verilog/stat_top.sv
sim/stat_checker.sv
sim/tb_stat_top.sv

/* include/stat_params.svh */
// image statistics parameters
// widths, counter sizes and interrupt pulse length
`ifndef STAT_PARAMS_SVH
`define STAT_PARAMS_SVH

// sensor pixel width
`define PIX_W 10
// grey sum width
`define SUM_W 48
// window and coordinate counters
`define COORD_W 12
// register bank data and address
`define REG_W 32
`define ADDR_W 3
// interrupt pulse length in cycles
`define INT_LEN 4
// completed frame counter
`define FRAME_CNT_W 16

`endif

/* run.sh */
#!/bin/sh
# compile and run the image statistics testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_stat_top -f flist.f --Mdir "$OBJ" -o sim_stat
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$OBJ/sim_stat" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* sim/stat_checker.sv */
// statistics checker
// watches the stat_top ports, models the window, the grey sum,
// the irq timing and the register map, and counts mismatches
`timescale 1ns/1ps
`include "stat_params.svh"

module stat_checker (
	input logic                clk,
	input logic                rst_n,
	input logic                fval,
	input logic                lval,
	input stat_pkg::pix_t      pix_data,
	input logic                wr_en,
	input stat_pkg::reg_addr_e addr,
	input stat_pkg::reg_t      wdata,
	input stat_pkg::reg_t      rdata,
	input logic                irq,
	input stat_pkg::sum_t      grey_sum
);
	import stat_pkg::*;

	int errors = 0;
	int checks = 0;

	// register map model
	coord_t off_x;
	coord_t off_y;
	coord_t win_w;
	coord_t win_h;
	logic   int_en;
	int     frame_cnt;
	sum_t   latched;
	// frame in flight, geometry frozen at its start
	int     sh_x;
	int     sh_y;
	int     sh_w;
	int     sh_h;
	int     col;
	int     row;
	sum_t   run_sum;
	sum_t   done_sum;
	// last samples and irq expectation
	logic   fval_q;
	logic   lval_q;
	logic   irq_q;
	logic   fall_seen;
	logic   irq_due;
	int     high_cnt;

	task automatic compare_value(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error at %0t: %s expected %0h actual %0h", $time, name, exp, act);
		end
	endtask

	// readback per register map
	function automatic reg_t read_model(input reg_addr_e a);
		case (a)
			REG_OFFSET_X:  return reg_t'(off_x);
			REG_OFFSET_Y:  return reg_t'(off_y);
			REG_WIDTH:     return reg_t'(win_w);
			REG_HEIGHT:    return reg_t'(win_h);
			REG_INT_EN:    return reg_t'(int_en);
			REG_SUM_LO:    return latched[`REG_W-1:0];
			REG_SUM_HI:    return reg_t'(latched[`SUM_W-1:`REG_W]);
			REG_FRAME_CNT: return reg_t'(frame_cnt[`FRAME_CNT_W-1:0]);
			default:       return '0;
		endcase
	endfunction

	function automatic bit in_window(input int c, input int r);
		return c >= sh_x && c < sh_x + sh_w && r >= sh_y && r < sh_y + sh_h;
	endfunction

	// ----------------------------------------
	// per cycle compare, then model update
	// ----------------------------------------
	always @(posedge clk) begin
		if (!rst_n) begin
			off_x     = '0;
			off_y     = '0;
			win_w     = '0;
			win_h     = '0;
			int_en    = 1'b0;
			frame_cnt = 0;
			latched   = '0;
			run_sum   = '0;
			done_sum  = '0;
			col       = 0;
			row       = 0;
			fval_q    = 1'b0;
			lval_q    = 1'b0;
			irq_q     = 1'b0;
			fall_seen = 1'b0;
			irq_due   = 1'b0;
			high_cnt  = 0;
		end else begin
			// values seen here are all from before this edge
			compare_value("rdata", read_model(addr), rdata);
			compare_value("grey_sum", latched, grey_sum);

			// irq two samples after fval falls, only when enabled
			if (irq && !irq_q && !irq_due) begin
				errors++;
				$display("irq rose at %0t without an enabled frame end", $time);
			end
			if (irq_due && !irq) begin
				errors++;
				$display("irq missing at %0t after an enabled frame end", $time);
			end
			if (irq) begin
				high_cnt++;
			end else if (irq_q) begin
				compare_value("irq pulse length", 64'(`INT_LEN), 64'(high_cnt));
				high_cnt = 0;
			end
			// capture and frame count follow the irq rise
			if (irq && !irq_q) begin
				latched   = done_sum;
				frame_cnt = frame_cnt + 1;
			end
			// enable as it stands one cycle after the frame end
			irq_due   = fall_seen && int_en;
			fall_seen = 1'b0;

			// window and sum, geometry before this edge's write
			if (fval && !fval_q) begin
				sh_x    = int'(off_x);
				sh_y    = int'(off_y);
				sh_w    = int'(win_w);
				sh_h    = int'(win_h);
				col     = 0;
				row     = 0;
				run_sum = '0;
			end
			if (fval && lval) begin
				// top 8 bits of the pixel
				if (in_window(col, row))
					run_sum = run_sum + sum_t'(pix_data[`PIX_W-1 -: 8]);
				col++;
			end else begin
				col = 0;
			end
			if (lval_q && !lval)
				row++;
			if (fval_q && !fval) begin
				done_sum  = run_sum;
				fall_seen = 1'b1;
			end

			// register writes, read-only addresses ignored
			if (wr_en) begin
				case (addr)
					REG_OFFSET_X: off_x  = wdata[`COORD_W-1:0];
					REG_OFFSET_Y: off_y  = wdata[`COORD_W-1:0];
					REG_WIDTH:    win_w  = wdata[`COORD_W-1:0];
					REG_HEIGHT:   win_h  = wdata[`COORD_W-1:0];
					REG_INT_EN:   int_en = wdata[0];
					default:      ;
				endcase
			end
			fval_q = fval;
			lval_q = lval;
			irq_q  = irq;
		end
	end

endmodule

/* sim/tb_stat_top.sv */
// image statistics testbench
// random frames and register traffic into stat_top from an
// xorshift source, stat_checker does the comparing
`timescale 1ns/1ps
`include "stat_params.svh"

module tb_stat_top;
	import stat_pkg::*;

	localparam int NUM_FRAMES  = 40;
	// cycles allowed for each irq edge
	localparam int IRQ_TIMEOUT = 4 * `INT_LEN + 8;

	logic      clk;
	logic      rst_n;
	logic      fval;
	logic      lval;
	pix_t      pix_data;
	logic      wr_en;
	reg_addr_e addr;
	reg_t      wdata;
	reg_t      rdata;
	logic      irq;
	sum_t      grey_sum;

	logic [31:0] rng;
	int          timeouts;

	stat_top uut (.*);

	stat_checker chk (.*);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ----------------------------------------
	// random numbers
	// ----------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// uniform in 0..span-1
	function automatic int pick_below(input int span);
		rng = xorshift32(rng);
		return int'(rng % 32'(span));
	endfunction

	// ----------------------------------------
	// bus and sensor drivers
	// ----------------------------------------
	task automatic write_reg(input int a, input reg_t d);
		@(posedge clk);
		wr_en <= 1'b1;
		addr  <= reg_addr_e'(a[`ADDR_W-1:0]);
		wdata <= d;
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	// rdata is compared while the address is held
	task automatic read_reg(input int a);
		@(posedge clk);
		wr_en <= 1'b0;
		addr  <= reg_addr_e'(a[`ADDR_W-1:0]);
	endtask

	// one sensor cycle inside a frame, bus traffic alongside
	task automatic pixel_cycle(input bit lv);
		int   a;
		reg_t d;
		@(posedge clk);
		fval     <= 1'b1;
		lval     <= lv;
		pix_data <= pix_t'(pick_below(1 << `PIX_W));
		a = pick_below(8);
		if (pick_below(16) == 0) begin
			// geometry for the next frame, sometimes a read-only address
			if (a == int'(REG_INT_EN))
				a = int'(REG_FRAME_CNT);
			d = reg_t'(pick_below(20));
			d[31:16] = 16'(pick_below(1 << 16));
			wr_en <= 1'b1;
			wdata <= d;
		end else begin
			wr_en <= 1'b0;
		end
		addr <= reg_addr_e'(a[`ADDR_W-1:0]);
	endtask

	task automatic send_frame(input int cols, input int rows, input int gap);
		for (int r = 0; r < rows; r++) begin
			repeat (gap) pixel_cycle(1'b0);
			repeat (cols) pixel_cycle(1'b1);
		end
		repeat (gap) pixel_cycle(1'b0);
		@(posedge clk);
		fval  <= 1'b0;
		lval  <= 1'b0;
		wr_en <= 1'b0;
	endtask

	// ----------------------------------------
	// bounded waits on irq
	// ----------------------------------------
	task automatic wait_irq_rise(input int limit, output bit seen);
		logic prev;
		prev = irq;
		seen = 1'b0;
		for (int n = 0; n < limit && !seen; n++) begin
			@(posedge clk);
			seen = irq && !prev;
			prev = irq;
		end
	endtask

	task automatic wait_irq_fall(input int limit, output bit low);
		low = !irq;
		for (int n = 0; n < limit && !low; n++) begin
			@(posedge clk);
			low = !irq;
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int   cols;
		int   rows;
		int   gap;
		bit   en;
		bit   ok;
		reg_t d;
		rng      = 32'd40732;
		timeouts = 0;
		rst_n    = 1'b0;
		fval     = 1'b0;
		lval     = 1'b0;
		pix_data = '0;
		wr_en    = 1'b0;
		addr     = REG_OFFSET_X;
		wdata    = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		// reset values on every address
		for (int a = 0; a < 8; a++)
			read_reg(a);

		for (int f = 0; f < NUM_FRAMES && timeouts == 0; f++) begin
			cols = 1 + pick_below(24);
			rows = 1 + pick_below(12);
			gap  = 1 + pick_below(4);
			// otherwise this frame runs on what the last one wrote
			if (pick_below(4) != 0) begin
				write_reg(REG_OFFSET_X, reg_t'(pick_below(cols + 4)));
				write_reg(REG_OFFSET_Y, reg_t'(pick_below(rows + 4)));
				write_reg(REG_WIDTH, reg_t'(pick_below(cols + 4)));
				write_reg(REG_HEIGHT, reg_t'(pick_below(rows + 4)));
			end
			en = (pick_below(4) != 0);
			d = reg_t'(pick_below(1 << 30));
			d[0] = en;
			write_reg(REG_INT_EN, d);
			for (int a = 0; a < 5; a++)
				read_reg(a);

			send_frame(cols, rows, gap);
			// disabled frames just sit out the timeout
			wait_irq_rise(IRQ_TIMEOUT, ok);
			if (en && !ok) begin
				$display("timeout: no irq after the end of frame %0d", f);
				timeouts++;
			end else if (en) begin
				wait_irq_fall(IRQ_TIMEOUT, ok);
				if (!ok) begin
					$display("timeout: irq stuck high after frame %0d", f);
					timeouts++;
				end
			end
			// latched sum and frame count
			for (int a = 5; a < 8; a++)
				read_reg(a);
		end
		repeat (2) @(posedge clk);

		$display("checks %0d, errors %0d, timeouts %0d", chk.checks, chk.errors, timeouts);
		if (chk.errors == 0 && timeouts == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* verilog/aoi_window.sv */
// area-of-interest window
// delays the sensor timing by one cycle and keeps lval only
// for pixels inside the programmed rectangle
`timescale 1ns/1ps
`include "stat_params.svh"

module aoi_window (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            fval,
	input  logic            lval,
	input  stat_pkg::pix_t  pix_data,
	input  stat_pkg::coord_t offset_x,
	input  stat_pkg::coord_t offset_y,
	input  stat_pkg::coord_t width,
	input  stat_pkg::coord_t height,
	output logic            aoi_fval,
	output logic            aoi_lval,
	output stat_pkg::pix_t  aoi_pix
);
	import stat_pkg::*;

	// raw lval one cycle late, for line end detect
	logic   lval_d;
	logic   frame_start;
	logic   line_end;
	// position of the pixel at the input
	coord_t col_cnt;
	coord_t line_cnt;
	coord_t cur_col;
	coord_t cur_line;
	// geometry frozen at frame start
	coord_t sh_off_x;
	coord_t sh_off_y;
	coord_t sh_width;
	coord_t sh_height;
	coord_t use_off_x;
	coord_t use_off_y;
	coord_t use_width;
	coord_t use_height;
	logic   col_in;
	logic   line_in;

	// ----------------------------------------
	// edges and current position
	// ----------------------------------------
	// aoi_fval doubles as the delayed fval
	assign frame_start = fval & ~aoi_fval;
	assign line_end    = lval_d & ~lval;

	// first cycle of a frame sees zero position and the live geometry
	assign cur_col    = frame_start ? '0 : col_cnt;
	assign cur_line   = frame_start ? '0 : line_cnt;
	assign use_off_x  = frame_start ? offset_x : sh_off_x;
	assign use_off_y  = frame_start ? offset_y : sh_off_y;
	assign use_width  = frame_start ? width : sh_width;
	assign use_height = frame_start ? height : sh_height;

	// one extra bit so offset plus size cannot wrap
	assign col_in  = ({1'b0, cur_col} >= {1'b0, use_off_x}) &&
		({1'b0, cur_col} < ({1'b0, use_off_x} + {1'b0, use_width}));
	assign line_in = ({1'b0, cur_line} >= {1'b0, use_off_y}) &&
		({1'b0, cur_line} < ({1'b0, use_off_y} + {1'b0, use_height}));

	// ----------------------------------------
	// counters and shadow geometry
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			col_cnt   <= '0;
			line_cnt  <= '0;
			sh_off_x  <= '0;
			sh_off_y  <= '0;
			sh_width  <= '0;
			sh_height <= '0;
		end else begin
			// column restarts whenever lval drops
			col_cnt  <= lval ? cur_col + 1'b1 : '0;
			line_cnt <= line_end ? cur_line + 1'b1 : cur_line;
			if (frame_start) begin
				sh_off_x  <= offset_x;
				sh_off_y  <= offset_y;
				sh_width  <= width;
				sh_height <= height;
			end
		end
	end

	// ----------------------------------------
	// one cycle output stage
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			aoi_fval <= 1'b0;
			aoi_lval <= 1'b0;
			lval_d   <= 1'b0;
		end else begin
			aoi_fval <= fval;
			lval_d   <= lval;
			// in-window pixels only
			aoi_lval <= lval & col_in & line_in;
		end
	end

	// pixel data just rides along
	always_ff @(posedge clk) begin
		aoi_pix <= pix_data;
	end

	// windowed lval never escapes the frame
	a_lval_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
		aoi_lval |-> aoi_fval);

endmodule

/* verilog/frame_interrupt.sv */
// frame end interrupt
// fixed-length irq pulse after each frame end when enabled
`timescale 1ns/1ps
`include "stat_params.svh"

module frame_interrupt (
	input  logic clk,
	input  logic rst_n,
	input  logic aoi_fval,
	input  logic int_enable,
	output logic irq
);
	// room for INT_LEN-1 down to zero
	localparam int CNT_W = $clog2(`INT_LEN + 1);

	logic             fval_d;
	logic             fval_fall;
	logic [CNT_W-1:0] len_cnt;

	assign fval_fall = fval_d & ~aoi_fval;

	// ----------------------------------------
	// pulse generator
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fval_d  <= 1'b0;
			irq     <= 1'b0;
			len_cnt <= '0;
		end else begin
			fval_d <= aoi_fval;
			if (fval_fall && int_enable) begin
				// enable sampled at the frame end only
				irq     <= 1'b1;
				len_cnt <= CNT_W'(`INT_LEN - 1);
			end else if (irq) begin
				if (len_cnt == '0)
					irq <= 1'b0;
				else
					len_cnt <= len_cnt - 1'b1;
			end
		end
	end

	// pulse width fixed at INT_LEN
	a_irq_len: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(irq) |-> irq [*`INT_LEN] ##1 !irq);

endmodule

/* verilog/grey_statis.sv */
// grey statistics
// sums the top 8 bits of every windowed pixel in a frame and
// captures the sum on the interrupt rising edge
`timescale 1ns/1ps
`include "stat_params.svh"

module grey_statis (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           aoi_fval,
	input  logic           aoi_lval,
	input  stat_pkg::pix_t aoi_pix,
	input  logic           irq,
	output stat_pkg::sum_t grey_sum
);
	import stat_pkg::*;

	// bits of each pixel that count
	localparam int GREY_W = 8;

	logic              fval_d;
	logic              irq_d;
	logic              fval_rise;
	logic              irq_rise;
	logic [GREY_W-1:0] grey8;
	sum_t              grey_ext;
	sum_t              acc;

	// ----------------------------------------
	// edge detect
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fval_d <= 1'b0;
			irq_d  <= 1'b0;
		end else begin
			fval_d <= aoi_fval;
			irq_d  <= irq;
		end
	end

	assign fval_rise = aoi_fval & ~fval_d;
	assign irq_rise  = irq & ~irq_d;

	// msb slice of the pixel, zero extended
	assign grey8    = aoi_pix[`PIX_W-1 -: GREY_W];
	assign grey_ext = {{(`SUM_W-GREY_W){1'b0}}, grey8};

	// ----------------------------------------
	// accumulate and capture
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc      <= '0;
			grey_sum <= '0;
		end else begin
			// new frame restarts from this cycle's pixel
			if (fval_rise)
				acc <= aoi_lval ? grey_ext : '0;
			else if (aoi_lval)
				acc <= acc + grey_ext;
			// held until the next interrupt
			if (irq_rise)
				grey_sum <= acc;
		end
	end

	// sum only grows between frame starts
	a_acc_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
		!fval_rise |=> (acc >= $past(acc)));

endmodule

/* verilog/stat_pkg.sv */
// image statistics types
// pixel, sum, coordinate and register address types
`include "stat_params.svh"

package stat_pkg;

	// one sensor pixel
	typedef logic [`PIX_W-1:0] pix_t;
	// accumulated grey sum
	typedef logic [`SUM_W-1:0] sum_t;
	// column or line number
	typedef logic [`COORD_W-1:0] coord_t;
	// register data word
	typedef logic [`REG_W-1:0] reg_t;

	// register map, 5..7 are read only
	typedef enum logic [`ADDR_W-1:0] {
		REG_OFFSET_X  = 0,
		REG_OFFSET_Y  = 1,
		REG_WIDTH     = 2,
		REG_HEIGHT    = 3,
		REG_INT_EN    = 4,
		REG_SUM_LO    = 5,
		REG_SUM_HI    = 6,
		REG_FRAME_CNT = 7
	} reg_addr_e;

endpackage

/* verilog/stat_regs.sv */
// statistics register bank
// window geometry, interrupt enable, sum readback and frame count
// write on wr_en, combinational read
`timescale 1ns/1ps
`include "stat_params.svh"

module stat_regs (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                wr_en,
	input  stat_pkg::reg_addr_e addr,
	input  stat_pkg::reg_t      wdata,
	output stat_pkg::reg_t      rdata,
	input  stat_pkg::sum_t      grey_sum,
	input  logic                irq,
	output stat_pkg::coord_t    offset_x,
	output stat_pkg::coord_t    offset_y,
	output stat_pkg::coord_t    width,
	output stat_pkg::coord_t    height,
	output logic                int_enable
);
	import stat_pkg::*;

	logic                    irq_d;
	logic [`FRAME_CNT_W-1:0] frame_cnt;

	// ----------------------------------------
	// writable registers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			offset_x   <= '0;
			offset_y   <= '0;
			width      <= '0;
			height     <= '0;
			int_enable <= 1'b0;
		end else if (wr_en) begin
			// read-only addresses fall through
			case (addr)
				REG_OFFSET_X: offset_x   <= wdata[`COORD_W-1:0];
				REG_OFFSET_Y: offset_y   <= wdata[`COORD_W-1:0];
				REG_WIDTH:    width      <= wdata[`COORD_W-1:0];
				REG_HEIGHT:   height     <= wdata[`COORD_W-1:0];
				REG_INT_EN:   int_enable <= wdata[0];
				default:      ;
			endcase
		end
	end

	// ----------------------------------------
	// frame counter
	// ----------------------------------------
	// one count per irq pulse
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			irq_d     <= 1'b0;
			frame_cnt <= '0;
		end else begin
			irq_d <= irq;
			if (irq && !irq_d)
				frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// ----------------------------------------
	// read mux
	// ----------------------------------------
	always_comb begin
		case (addr)
			REG_OFFSET_X:  rdata = reg_t'(offset_x);
			REG_OFFSET_Y:  rdata = reg_t'(offset_y);
			REG_WIDTH:     rdata = reg_t'(width);
			REG_HEIGHT:    rdata = reg_t'(height);
			REG_INT_EN:    rdata = reg_t'(int_enable);
			REG_SUM_LO:    rdata = grey_sum[`REG_W-1:0];
			// upper part of the sum, zero padded
			REG_SUM_HI:    rdata = reg_t'(grey_sum[`SUM_W-1:`REG_W]);
			REG_FRAME_CNT: rdata = reg_t'(frame_cnt);
			default:       rdata = '0;
		endcase
	end

endmodule

/* verilog/stat_top.sv */
// image statistics top level
// window stage, grey statistics, frame interrupt and register bank
`timescale 1ns/1ps

module stat_top (
	input  logic                clk,
	input  logic                rst_n,
	// sensor side
	input  logic                fval,
	input  logic                lval,
	input  stat_pkg::pix_t      pix_data,
	// software side
	input  logic                wr_en,
	input  stat_pkg::reg_addr_e addr,
	input  stat_pkg::reg_t      wdata,
	output stat_pkg::reg_t      rdata,
	output logic                irq,
	output stat_pkg::sum_t      grey_sum
);
	import stat_pkg::*;

	// window output stream
	logic   aoi_fval;
	logic   aoi_lval;
	pix_t   aoi_pix;
	// geometry and enable from the bank
	coord_t offset_x;
	coord_t offset_y;
	coord_t width;
	coord_t height;
	logic   int_enable;

	// ----------------------------------------
	// datapath
	// ----------------------------------------
	aoi_window u_aoi_window (
		.clk      (clk),
		.rst_n    (rst_n),
		.fval     (fval),
		.lval     (lval),
		.pix_data (pix_data),
		.offset_x (offset_x),
		.offset_y (offset_y),
		.width    (width),
		.height   (height),
		.aoi_fval (aoi_fval),
		.aoi_lval (aoi_lval),
		.aoi_pix  (aoi_pix)
	);

	grey_statis u_grey_statis (
		.clk      (clk),
		.rst_n    (rst_n),
		.aoi_fval (aoi_fval),
		.aoi_lval (aoi_lval),
		.aoi_pix  (aoi_pix),
		.irq      (irq),
		.grey_sum (grey_sum)
	);

	// ----------------------------------------
	// control
	// ----------------------------------------
	frame_interrupt u_frame_interrupt (
		.clk        (clk),
		.rst_n      (rst_n),
		.aoi_fval   (aoi_fval),
		.int_enable (int_enable),
		.irq        (irq)
	);

	stat_regs u_stat_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.addr       (addr),
		.wdata      (wdata),
		.rdata      (rdata),
		.grey_sum   (grey_sum),
		.irq        (irq),
		.offset_x   (offset_x),
		.offset_y   (offset_y),
		.width      (width),
		.height     (height),
		.int_enable (int_enable)
	);

endmodule
